// File: source/cpu_pkg.sv
package cpu_pkg;

    // datapath widths
    localparam int xlen = 64;
    localparam int reg_addr_w = 5;
    localparam int nregs = 1 << reg_addr_w;

    // first fetch address
    localparam logic [xlen-1:0] reset_pc = '0;

    // ecall encoding, ends the program
    localparam logic [31:0] ecall_word = 32'h0000_0073;

    // funct3 codes for the alu group
    localparam logic [2:0] f3_add = 3'b000;
    localparam logic [2:0] f3_slt = 3'b010;
    localparam logic [2:0] f3_xor = 3'b100;
    localparam logic [2:0] f3_or = 3'b110;
    localparam logic [2:0] f3_and = 3'b111;
    // doubleword width, the only one for ld/sd
    localparam logic [2:0] f3_dword = 3'b011;
    // branch compares
    localparam logic [2:0] f3_beq = 3'b000;
    localparam logic [2:0] f3_bne = 3'b001;
    // funct7 bit selecting sub over add
    localparam int f7_sub_bit = 30;

    // major opcodes in use
    typedef enum logic [6:0] {
        op_lui = 7'b0110111,
        op_opimm = 7'b0010011,
        op_op = 7'b0110011,
        op_load = 7'b0000011,
        op_store = 7'b0100011,
        op_branch = 7'b1100011,
        op_jal = 7'b1101111,
        op_system = 7'b1110011
    } opcode_e;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,
        alu_pass_b
    } alu_op_e;

endpackage

// File: source/cpu_stage_if.sv
`timescale 1ns/1ps

// decode to execute, redirect flows back
interface dec_ex_if import cpu_pkg::*; ();
    logic valid;
    logic ready;
    logic [xlen-1:0] pc;
    logic [reg_addr_w-1:0] rd;
    logic reg_wr;
    alu_op_e alu_op;
    logic [xlen-1:0] src1;
    logic [xlen-1:0] src2;
    logic [xlen-1:0] imm;
    logic use_imm;
    logic is_load;
    logic is_store;
    logic is_branch_ne;
    logic is_branch;
    logic is_jal;
    logic is_done;
    logic error;
    // taken branch or jal leaving execute
    logic redirect;
    logic [xlen-1:0] redirect_pc;

    modport source (
        output valid, pc, rd, reg_wr, alu_op, src1, src2, imm, use_imm, is_load,
               is_store, is_branch_ne, is_branch, is_jal, is_done, error,
        input ready, redirect, redirect_pc
    );
    modport sink (
        input valid, pc, rd, reg_wr, alu_op, src1, src2, imm, use_imm, is_load,
              is_store, is_branch_ne, is_branch, is_jal, is_done, error,
        output ready, redirect, redirect_pc
    );
endinterface

// execute to result
interface ex_res_if import cpu_pkg::*; ();
    logic valid;
    logic ready;
    logic [reg_addr_w-1:0] rd;
    logic reg_wr;
    // alu value, link value or memory address
    logic [xlen-1:0] result;
    logic [xlen-1:0] store_data;
    logic is_load;
    logic is_store;
    logic is_done;
    logic error;
    logic [xlen-1:0] pc_nxt;

    modport source (
        output valid, rd, reg_wr, result, store_data, is_load, is_store, is_done,
               error, pc_nxt,
        input ready
    );
    modport sink (
        input valid, rd, reg_wr, result, store_data, is_load, is_store, is_done,
              error, pc_nxt,
        output ready
    );
endinterface

// File: source/cpu_regfile.sv
`timescale 1ns/1ps

module cpu_regfile import cpu_pkg::*; (
    input logic clk,
    input logic rst,
    input logic wr_en,
    input logic [reg_addr_w-1:0] wr_addr,
    input logic [xlen-1:0] wr_data,
    input logic [reg_addr_w-1:0] rs1,
    input logic [reg_addr_w-1:0] rs2,
    output logic [xlen-1:0] src1,
    output logic [xlen-1:0] src2,
    input logic issue_en,
    input logic [reg_addr_w-1:0] issue_rd,
    output logic busy1,
    output logic busy2
);
    logic [xlen-1:0] regs [nregs];
    logic [nregs-1:0] busy_q;
    logic [nregs-1:0] clr;
    logic [nregs-1:0] set;
    logic [nregs-1:0] busy_now;

    // reads see a same-cycle write, x0 reads zero
    assign src1 = (rs1 == '0) ? '0 : (wr_en && wr_addr == rs1) ? wr_data : regs[rs1];
    assign src2 = (rs2 == '0) ? '0 : (wr_en && wr_addr == rs2) ? wr_data : regs[rs2];

    // scoreboard, a write this cycle already frees its register
    assign clr = wr_en ? (nregs'(1) << wr_addr) : '0;
    assign set = issue_en ? (nregs'(1) << issue_rd) : '0;
    assign busy_now = busy_q & ~clr;
    assign busy1 = busy_now[rs1];
    // busy2 also covers the destination, which blocks write-after-write
    assign busy2 = busy_now[rs2] | busy_now[issue_rd];

    always_ff @(posedge clk) begin
        if (wr_en && wr_addr != '0) begin
            regs[wr_addr] <= wr_data;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            busy_q <= '0;
        end else begin
            // x0 never tracked
            busy_q <= (busy_now | set) & ~nregs'(1);
        end
    end

    // decode must hold back on a destination still in flight
    assert property (@(posedge clk) disable iff (!rst)
        issue_en && issue_rd != '0 |-> !busy_now[issue_rd]);

endmodule

// File: source/cpu_decode.sv
`timescale 1ns/1ps

module cpu_decode import cpu_pkg::*; (
    input logic clk,
    input logic rst,
    input logic [31:0] instr,
    input logic instr_valid,
    input logic instr_error,
    output logic [xlen-1:0] pc_rd,
    dec_ex_if.source dx,
    output logic [reg_addr_w-1:0] rs1,
    output logic [reg_addr_w-1:0] rs2,
    input logic [xlen-1:0] src1,
    input logic [xlen-1:0] src2,
    input logic busy1,
    input logic busy2,
    output logic issue_en,
    output logic [reg_addr_w-1:0] issue_rd
);
    logic hold_v;
    logic [31:0] hold_instr;
    logic [xlen-1:0] hold_pc;
    logic hold_err;
    logic stop_q;
    logic fetch;
    logic issue;
    logic err;
    opcode_e opc;
    logic [2:0] f3;
    logic [xlen-1:0] imm_i;
    logic [xlen-1:0] imm_s;
    logic [xlen-1:0] imm_b;
    logic [xlen-1:0] imm_u;
    logic [xlen-1:0] imm_j;
    alu_op_e alu_op;
    logic [xlen-1:0] imm;
    logic use_imm;
    logic use1;
    logic use2;
    logic reg_wr;
    logic is_load;
    logic is_store;
    logic is_branch;
    logic is_jal;
    logic is_done;
    logic illegal;

    assign issue = dx.valid && dx.ready;
    // take a word only into a free or emptying slot
    assign fetch = instr_valid && !stop_q && !dx.redirect && (!hold_v || issue);

    always_ff @(posedge clk) begin
        if (!rst) begin
            pc_rd <= reset_pc;
            hold_v <= 1'b0;
            stop_q <= 1'b0;
        end else if (dx.redirect) begin
            // drop the wrong-path word, restart at the target
            pc_rd <= dx.redirect_pc;
            hold_v <= 1'b0;
            stop_q <= 1'b0;
        end else begin
            if (fetch) begin
                pc_rd <= pc_rd + xlen'(4);
                // no fetch past ecall
                stop_q <= (instr == ecall_word) && !instr_error;
            end
            hold_v <= fetch || (hold_v && !issue);
        end
    end

    always_ff @(posedge clk) begin
        if (fetch) begin
            hold_instr <= instr;
            hold_pc <= pc_rd;
            hold_err <= instr_error;
        end
    end

    assign opc = opcode_e'(hold_instr[6:0]);
    assign f3 = hold_instr[14:12];
    assign imm_i = {{(xlen-12){hold_instr[31]}}, hold_instr[31:20]};
    assign imm_s = {{(xlen-12){hold_instr[31]}}, hold_instr[31:25], hold_instr[11:7]};
    assign imm_b = {{(xlen-12){hold_instr[31]}}, hold_instr[7], hold_instr[30:25],
                    hold_instr[11:8], 1'b0};
    assign imm_u = {{(xlen-32){hold_instr[31]}}, hold_instr[31:12], 12'b0};
    assign imm_j = {{(xlen-20){hold_instr[31]}}, hold_instr[19:12], hold_instr[20],
                    hold_instr[30:21], 1'b0};

    always_comb begin
        alu_op = alu_add;
        imm = imm_i;
        use_imm = 1'b1;
        use1 = 1'b0;
        use2 = 1'b0;
        reg_wr = 1'b0;
        is_load = 1'b0;
        is_store = 1'b0;
        is_branch = 1'b0;
        is_jal = 1'b0;
        is_done = 1'b0;
        illegal = 1'b0;
        case (opc)
            op_lui: begin
                imm = imm_u;
                alu_op = alu_pass_b;
                reg_wr = 1'b1;
            end
            op_opimm, op_op: begin
                use1 = 1'b1;
                use2 = (opc == op_op);
                use_imm = (opc == op_opimm);
                reg_wr = 1'b1;
                case (f3)
                    f3_add: alu_op = (use2 && hold_instr[f7_sub_bit]) ? alu_sub : alu_add;
                    f3_slt: alu_op = alu_slt;
                    f3_xor: alu_op = alu_xor;
                    f3_or: alu_op = alu_or;
                    f3_and: alu_op = alu_and;
                    // shifts not supported
                    default: illegal = 1'b1;
                endcase
            end
            op_load: begin
                use1 = 1'b1;
                reg_wr = 1'b1;
                is_load = 1'b1;
                illegal = (f3 != f3_dword);
            end
            op_store: begin
                imm = imm_s;
                use1 = 1'b1;
                use2 = 1'b1;
                is_store = 1'b1;
                illegal = (f3 != f3_dword);
            end
            op_branch: begin
                imm = imm_b;
                use_imm = 1'b0;
                use1 = 1'b1;
                use2 = 1'b1;
                is_branch = 1'b1;
                illegal = (f3 != f3_beq) && (f3 != f3_bne);
            end
            op_jal: begin
                imm = imm_j;
                reg_wr = 1'b1;
                is_jal = 1'b1;
            end
            op_system: begin
                is_done = (hold_instr == ecall_word);
                illegal = !is_done;
            end
            default: illegal = 1'b1;
        endcase
    end

    assign err = illegal || hold_err;

    // unused sources read x0, which is never busy
    assign rs1 = use1 ? hold_instr[19:15] : '0;
    assign rs2 = use2 ? hold_instr[24:20] : '0;
    assign issue_en = issue && dx.reg_wr;
    assign issue_rd = dx.reg_wr ? hold_instr[11:7] : '0;

    // stall while a source or the destination is in flight
    assign dx.valid = hold_v && !busy1 && !busy2;
    assign dx.pc = hold_pc;
    assign dx.rd = hold_instr[11:7];
    assign dx.alu_op = alu_op;
    assign dx.src1 = src1;
    assign dx.src2 = src2;
    assign dx.imm = imm;
    assign dx.use_imm = use_imm;
    // an erroring instruction only retires
    assign dx.reg_wr = reg_wr && !err;
    assign dx.is_load = is_load && !err;
    assign dx.is_store = is_store && !err;
    assign dx.is_branch = is_branch && !err;
    assign dx.is_branch_ne = (f3 == f3_bne);
    assign dx.is_jal = is_jal && !err;
    assign dx.is_done = is_done && !err;
    assign dx.error = err;

    // targets from execute keep the fetch address word aligned
    assert property (@(posedge clk) disable iff (!rst) pc_rd[1:0] == 2'b00);

endmodule

// File: source/cpu_execute.sv
`timescale 1ns/1ps

module cpu_execute import cpu_pkg::*; (
    input logic clk,
    input logic rst,
    dec_ex_if.sink dx,
    ex_res_if.source xr
);
    logic full_q;
    logic taken_q;
    logic taken;
    logic [xlen-1:0] op_b;
    logic [xlen-1:0] alu_out;
    logic [xlen-1:0] link;
    logic [xlen-1:0] target;

    assign op_b = dx.use_imm ? dx.imm : dx.src2;

    always_comb begin
        case (dx.alu_op)
            alu_add: alu_out = dx.src1 + op_b;
            alu_sub: alu_out = dx.src1 - op_b;
            alu_and: alu_out = dx.src1 & op_b;
            alu_or: alu_out = dx.src1 | op_b;
            alu_xor: alu_out = dx.src1 ^ op_b;
            alu_slt: alu_out = xlen'($signed(dx.src1) < $signed(op_b));
            // lui
            alu_pass_b: alu_out = op_b;
            default: alu_out = '0;
        endcase
    end

    // jal link and fall-through pc
    assign link = dx.pc + xlen'(4);
    assign target = dx.pc + dx.imm;
    // beq takes on equal, bne on unequal
    assign taken = dx.is_jal ||
                   (dx.is_branch && ((dx.src1 == dx.src2) != dx.is_branch_ne));

    // one slot refilled as it drains unless the leaving item redirects
    assign dx.ready = !full_q || (xr.ready && !taken_q);
    assign dx.redirect = full_q && xr.ready && taken_q;
    assign dx.redirect_pc = xr.pc_nxt;
    assign xr.valid = full_q;

    always_ff @(posedge clk) begin
        if (!rst) begin
            full_q <= 1'b0;
        end else if (dx.valid && dx.ready) begin
            full_q <= 1'b1;
        end else if (xr.ready) begin
            full_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (dx.valid && dx.ready) begin
            xr.rd <= dx.rd;
            xr.reg_wr <= dx.reg_wr;
            // ld/sd address comes out of the adder
            xr.result <= dx.is_jal ? link : alu_out;
            xr.store_data <= dx.src2;
            xr.is_load <= dx.is_load;
            xr.is_store <= dx.is_store;
            xr.is_done <= dx.is_done;
            xr.error <= dx.error;
            xr.pc_nxt <= taken ? target : link;
            taken_q <= taken;
        end
    end

    // decode drops its wrong-path word on a redirect
    assert property (@(posedge clk) disable iff (!rst)
        dx.redirect |=> !dx.valid);

endmodule

// File: source/cpu_result.sv
`timescale 1ns/1ps

module cpu_result import cpu_pkg::*; (
    input logic clk,
    input logic rst,
    ex_res_if.sink xr,
    output logic mem_rd,
    output logic mem_wr,
    output logic [xlen-1:0] addr,
    output logic [xlen-1:0] data_wr,
    input logic [xlen-1:0] data_rd,
    input logic data_rd_valid,
    input logic data_rd_error,
    output logic wr_en,
    output logic [reg_addr_w-1:0] wr_addr,
    output logic [xlen-1:0] wr_data,
    output logic out_valid,
    output logic [xlen-1:0] pc_nxt,
    output logic [reg_addr_w-1:0] ret_rd,
    output logic [xlen-1:0] ret_data,
    output logic done,
    output logic error
);
    logic acc;
    logic ld_done;
    logic ret_fire;
    logic [reg_addr_w-1:0] ld_rd;
    logic [xlen-1:0] ld_pc_nxt;

    // mem_rd doubles as the load-pending flag
    assign xr.ready = !mem_rd;
    assign acc = xr.valid && xr.ready;
    assign ld_done = mem_rd && data_rd_valid;
    // non-loads retire straight from acceptance
    assign ret_fire = ld_done || (acc && !xr.is_load);

    // one write port, loads and accepts never coincide
    assign wr_en = ld_done || (acc && xr.reg_wr && !xr.is_load);
    assign wr_addr = ld_done ? ld_rd : xr.rd;
    // a failed read still frees rd, written as zero
    assign wr_data = ld_done ? (data_rd_error ? '0 : data_rd) : xr.result;

    always_ff @(posedge clk) begin
        if (!rst) begin
            mem_rd <= 1'b0;
            mem_wr <= 1'b0;
            out_valid <= 1'b0;
            done <= 1'b0;
            error <= 1'b0;
        end else begin
            if (acc && xr.is_load) begin
                mem_rd <= 1'b1;
            end else if (data_rd_valid) begin
                mem_rd <= 1'b0;
            end
            // single-cycle write strobe per store
            mem_wr <= acc && xr.is_store;
            out_valid <= ret_fire;
            done <= acc && xr.is_done;
            error <= (ld_done && data_rd_error) || (acc && xr.error);
        end
    end

    always_ff @(posedge clk) begin
        if (acc) begin
            addr <= xr.result;
            data_wr <= xr.store_data;
            ld_rd <= xr.rd;
            ld_pc_nxt <= xr.pc_nxt;
        end
        if (ret_fire) begin
            pc_nxt <= ld_done ? ld_pc_nxt : xr.pc_nxt;
            // zero when nothing is written
            ret_rd <= wr_en ? wr_addr : '0;
            ret_data <= wr_en ? wr_data : '0;
        end
    end

    // read and write requests stay apart on the data bus
    assert property (@(posedge clk) disable iff (!rst) !(mem_rd && mem_wr));

endmodule

// File: source/cpu_top.sv
`timescale 1ns/1ps

module cpu_top import cpu_pkg::*; (
    input logic clk,
    input logic rst,
    input logic [31:0] instr,
    input logic instr_valid,
    input logic instr_error,
    output logic [xlen-1:0] pc_rd,
    output logic mem_rd,
    output logic mem_wr,
    output logic [xlen-1:0] addr,
    output logic [xlen-1:0] data_wr,
    input logic [xlen-1:0] data_rd,
    input logic data_rd_valid,
    input logic data_rd_error,
    output logic out_valid,
    output logic [xlen-1:0] pc_nxt,
    output logic [reg_addr_w-1:0] ret_rd,
    output logic [xlen-1:0] ret_data,
    output logic done,
    output logic error
);
    // register file read side
    logic [reg_addr_w-1:0] rs1;
    logic [reg_addr_w-1:0] rs2;
    logic [xlen-1:0] src1;
    logic [xlen-1:0] src2;
    logic busy1;
    logic busy2;
    logic issue_en;
    logic [reg_addr_w-1:0] issue_rd;
    // write-back
    logic wr_en;
    logic [reg_addr_w-1:0] wr_addr;
    logic [xlen-1:0] wr_data;

    dec_ex_if dx ();
    ex_res_if xr ();

    cpu_decode cpu_decode_i (
        .clk(clk),
        .rst(rst),
        .instr(instr),
        .instr_valid(instr_valid),
        .instr_error(instr_error),
        .pc_rd(pc_rd),
        .dx(dx.source),
        .rs1(rs1),
        .rs2(rs2),
        .src1(src1),
        .src2(src2),
        .busy1(busy1),
        .busy2(busy2),
        .issue_en(issue_en),
        .issue_rd(issue_rd)
    );

    cpu_regfile cpu_regfile_i (
        .clk(clk),
        .rst(rst),
        .wr_en(wr_en),
        .wr_addr(wr_addr),
        .wr_data(wr_data),
        .rs1(rs1),
        .rs2(rs2),
        .src1(src1),
        .src2(src2),
        .issue_en(issue_en),
        .issue_rd(issue_rd),
        .busy1(busy1),
        .busy2(busy2)
    );

    cpu_execute cpu_execute_i (
        .clk(clk),
        .rst(rst),
        .dx(dx.sink),
        .xr(xr.source)
    );

    cpu_result cpu_result_i (
        .clk(clk),
        .rst(rst),
        .xr(xr.sink),
        .mem_rd(mem_rd),
        .mem_wr(mem_wr),
        .addr(addr),
        .data_wr(data_wr),
        .data_rd(data_rd),
        .data_rd_valid(data_rd_valid),
        .data_rd_error(data_rd_error),
        .wr_en(wr_en),
        .wr_addr(wr_addr),
        .wr_data(wr_data),
        .out_valid(out_valid),
        .pc_nxt(pc_nxt),
        .ret_rd(ret_rd),
        .ret_data(ret_data),
        .done(done),
        .error(error)
    );

endmodule

// File: dv/cpu_tb.sv
`timescale 1ns/1ps

module cpu_tb import cpu_pkg::*; ();

    // dut ports
    logic clk;
    logic rst = 1'b0;
    logic [31:0] instr = '0;
    logic instr_valid = 1'b0;
    logic instr_error = 1'b0;
    logic [xlen-1:0] pc_rd;
    logic mem_rd;
    logic mem_wr;
    logic [xlen-1:0] addr;
    logic [xlen-1:0] data_wr;
    logic [xlen-1:0] data_rd = '0;
    logic data_rd_valid = 1'b0;
    logic data_rd_error = 1'b0;
    logic out_valid;
    logic [xlen-1:0] pc_nxt;
    logic [reg_addr_w-1:0] ret_rd;
    logic [xlen-1:0] ret_data;
    logic done;
    logic error;

    // header words and program followed by six words per record
    logic [63:0] vec [0:255];
    logic [63:0] dmem [16];
    int n_prog = 0;
    int n_rec = 0;
    int limit = 0;
    int cycles = 0;
    int rec_idx = 0;
    int checks = 0;
    int errors = 0;
    // instruction model state
    logic [xlen-1:0] fetch_pc;
    int fetch_wait;
    // data model state
    logic rd_pending;
    int rd_wait;

    cpu_top cpu_top_i (
        .clk(clk),
        .rst(rst),
        .instr(instr),
        .instr_valid(instr_valid),
        .instr_error(instr_error),
        .pc_rd(pc_rd),
        .mem_rd(mem_rd),
        .mem_wr(mem_wr),
        .addr(addr),
        .data_wr(data_wr),
        .data_rd(data_rd),
        .data_rd_valid(data_rd_valid),
        .data_rd_error(data_rd_error),
        .out_valid(out_valid),
        .pc_nxt(pc_nxt),
        .ret_rd(ret_rd),
        .ret_data(ret_data),
        .done(done),
        .error(error)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    function automatic string test_name(input logic [63:0] id);
        case (id)
            64'd0: return "arith_chain";
            64'd1: return "memory";
            64'd2: return "control_flow";
            64'd3: return "illegal_opcode";
            64'd4: return "termination";
            default: return "unknown";
        endcase
    endfunction

    // words past the program read as zero
    function automatic logic [31:0] prog_word(input logic [xlen-1:0] pc);
        int idx;
        idx = int'(pc[11:2]);
        if (idx < n_prog) begin
            return vec[2 + idx][31:0];
        end
        return 32'h0;
    endfunction

    task automatic report_mismatch(input string label, input string field,
                                   input logic [63:0] exp, input logic [63:0] act);
        errors++;
        $display("Error: %s %s expected %h actual %h", label, field, exp, act);
    endtask

    task automatic check_reset();
        assert (pc_rd == reset_pc) else report_mismatch("reset", "pc_rd", reset_pc, pc_rd);
        assert (!out_valid) else report_mismatch("reset", "out_valid", 64'd0, 64'(out_valid));
        assert (!done) else report_mismatch("reset", "done", 64'd0, 64'(done));
        assert (!error) else report_mismatch("reset", "error", 64'd0, 64'(error));
        assert (!mem_rd) else report_mismatch("reset", "mem_rd", 64'd0, 64'(mem_rd));
        assert (!mem_wr) else report_mismatch("reset", "mem_wr", 64'd0, 64'(mem_wr));
    endtask

    task automatic check_record(input int idx);
        int base;
        string label;
        base = 2 + n_prog + 6 * idx;
        label = $sformatf("%s record %0d", test_name(vec[base]), idx);
        checks++;
        assert (pc_nxt == vec[base + 1])
            else report_mismatch(label, "pc_nxt", vec[base + 1], pc_nxt);
        assert (64'(ret_rd) == vec[base + 2])
            else report_mismatch(label, "ret_rd", vec[base + 2], 64'(ret_rd));
        assert (ret_data == vec[base + 3])
            else report_mismatch(label, "ret_data", vec[base + 3], ret_data);
        assert (64'(done) == vec[base + 4])
            else report_mismatch(label, "done", vec[base + 4], 64'(done));
        assert (64'(error) == vec[base + 5])
            else report_mismatch(label, "error", vec[base + 5], 64'(error));
    endtask

    // instruction model draws a 0 to 2 cycle latency per new address
    always @(negedge clk) begin
        if (!rst) begin
            instr_valid = 1'b0;
            fetch_pc = '1;
            fetch_wait = 0;
        end else begin
            if (pc_rd != fetch_pc) begin
                fetch_pc = pc_rd;
                fetch_wait = $urandom % 3;
            end else if (fetch_wait > 0) begin
                fetch_wait = fetch_wait - 1;
            end
            instr = prog_word(pc_rd);
            instr_valid = (fetch_wait == 0);
        end
    end

    // data model of 16 doublewords answering reads after 1 to 3 cycles
    always @(negedge clk) begin
        if (!rst) begin
            data_rd_valid = 1'b0;
            rd_pending = 1'b0;
            rd_wait = 0;
            for (int i = 0; i < 16; i++) begin
                dmem[i] = {32'hface_0000, 32'(i) * 32'h0101_0101};
            end
        end else begin
            // store strobe is a single cycle
            if (mem_wr) begin
                dmem[addr[6:3]] = data_wr;
            end
            if (mem_rd && !data_rd_valid) begin
                if (!rd_pending) begin
                    rd_pending = 1'b1;
                    rd_wait = 1 + $urandom % 3;
                end
                rd_wait = rd_wait - 1;
                if (rd_wait == 0) begin
                    data_rd = dmem[addr[6:3]];
                    data_rd_valid = 1'b1;
                    rd_pending = 1'b0;
                end
            end else begin
                data_rd_valid = 1'b0;
            end
        end
    end

    // retirement checker takes one record per out_valid cycle
    always @(negedge clk) begin
        if (!rst) begin
            check_reset();
        end else if (out_valid) begin
            assert (rec_idx < n_rec) else begin
                errors++;
                $display("Unexpected retirement after the last expected record, pc_nxt %h",
                         pc_nxt);
            end
            if (rec_idx < n_rec) begin
                check_record(rec_idx);
                rec_idx++;
            end
        end
    end

    // watchdog
    initial begin
        @(posedge clk);
        while (cycles < limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout after %0d cycles, %0d of %0d records retired, errors: %0d",
                 cycles, rec_idx, n_rec, errors);
        $display("Test failures found");
        $finish;
    end

    initial begin
        void'($urandom(32'hed2));
        $readmemh("dv/cpu_vectors.txt", vec);
        n_prog = int'(vec[0]);
        n_rec = int'(vec[1]);
        limit = 40 * n_rec;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst <= 1'b1;
        wait (rec_idx == n_rec);
        // nothing may retire after the ecall
        repeat (20) @(negedge clk);
        $display("Records checked: %0d of %0d, errors: %0d", checks, n_rec, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// File: dv/cpu_vectors.txt
// word 0 program length, word 1 record count, then program words from pc 0
// records: test id, pc_nxt, ret_rd, ret_data, done, error
15
12
// lui, addi, addi -1, add, sub, and, or, xor, slt
123450b7 67808113 fff00193 00310233
404102b3 00317333 0012e3b3 00314433
0051a4b3
// sd, ld, dependent add
00203823 01003503 005505b3
// beq taken, wrong-path addi, bne not taken, jal, wrong-path addi
00928463 7ff00613 00929463 008006ef
7ff00613
// illegal word, addi from the link, ecall, never fetched
ffffffff 00168713 00000073 00500793
// arithmetic chain
0 04 01 0000000012345000 0 0
0 08 02 0000000012345678 0 0
0 0c 03 ffffffffffffffff 0 0
0 10 04 0000000012345677 0 0
0 14 05 0000000000000001 0 0
0 18 06 0000000012345678 0 0
0 1c 07 0000000012345001 0 0
0 20 08 ffffffffedcba987 0 0
0 24 09 0000000000000001 0 0
// store, load, dependent add
1 28 00 0000000000000000 0 0
1 2c 0a 0000000012345678 0 0
1 30 0b 0000000012345679 0 0
// beq, bne, jal
2 38 00 0000000000000000 0 0
2 3c 00 0000000000000000 0 0
2 44 0d 0000000000000040 0 0
// illegal opcode, then execution goes on
3 48 00 0000000000000000 0 1
3 4c 0e 0000000000000041 0 0
// ecall
4 50 00 0000000000000000 1 0

// File: verilog.f
source/cpu_pkg.sv
source/cpu_stage_if.sv
source/cpu_regfile.sv
source/cpu_decode.sv
source/cpu_execute.sv
source/cpu_result.sv
source/cpu_top.sv
dv/cpu_tb.sv

// File: run.sh
#!/bin/sh
# compile and run the cpu testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f verilog.f --top-module cpu_tb -o cpu_sim
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

out=$(./obj_dir/cpu_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q 'All tests passed!'; then
    exit 0
fi
exit 1
